// ==== source/GamePkg.sv ====
`default_nettype none

////////////////////////////////////////
// battlefield geometry and tower
////////////////////////////////////////

package GamePkg;

	// position along the track, 0 at the friendly base
	typedef logic [8:0] posT;

	// tower hit points
	typedef logic [7:0] healthT;

	// attack of one unit, or the sum over the whole row
	typedef logic [7:0] damageT;

	// cycles counted by the game tick divider
	typedef logic [23:0] tickCountT;

	localparam posT TowerPos = 9'd320;
	localparam healthT TowerHealthInit = 8'd200;

endpackage

`default_nettype wire

// ==== source/UnitPkg.sv ====
`default_nettype none

////////////////////////////////////////
// unit kinds and their stats
////////////////////////////////////////

package UnitPkg;

	// kind as set on the switches
	typedef logic [1:0] unitKindT;

	typedef enum logic [1:0]
	{
		Idle,
		Marching,
		Sieging
	} unitStateT;

	// track distance covered per game tick
	function automatic GamePkg::posT kindSpeed(input unitKindT kind);
		case (kind)
			2'd0:    return GamePkg::posT'(1);
			2'd1:    return GamePkg::posT'(2);
			2'd2:    return GamePkg::posT'(1);
			default: return GamePkg::posT'(3);
		endcase
	endfunction

	// damage dealt to the tower per game tick once sieging
	// slow kinds hit harder
	function automatic GamePkg::damageT kindAttack(input unitKindT kind);
		case (kind)
			2'd0:    return GamePkg::damageT'(2);
			2'd1:    return GamePkg::damageT'(1);
			2'd2:    return GamePkg::damageT'(4);
			default: return GamePkg::damageT'(1);
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== source/GameSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module GameSequencer
#(
	parameter int NumUnits = 8,
	parameter int TickDiv = 1000000
)
(
	input wire logic ClkPort,
	input wire logic Reset,
	input wire logic Purchase,
	input wire UnitPkg::unitKindT KindSel,
	input wire logic [NumUnits-1:0] Busy,
	input wire logic GameOver,
	output logic Tick,
	output logic [NumUnits-1:0] Spawn,
	output UnitPkg::unitKindT SpawnKind
);

	GamePkg::tickCountT tickCount;
	logic [NumUnits-1:0] freeOneHot;
	logic anyFree;

	////////////////////////////////////////
	// game tick divider
	////////////////////////////////////////

	// counter freezes once the tower is down, so no more ticks
	always_ff @(posedge ClkPort, posedge Reset)
	begin
		if (Reset)
		begin
			tickCount <= '0;
			Tick <= 1'b0;
		end
		else if (GameOver)
			Tick <= 1'b0;
		else if (tickCount == GamePkg::tickCountT'(TickDiv - 1))
		begin
			tickCount <= '0;
			Tick <= 1'b1;
		end
		else
		begin
			tickCount <= tickCount + 1'b1;
			Tick <= 1'b0;
		end
	end

	////////////////////////////////////////
	// slot allocation
	////////////////////////////////////////

	assign anyFree = |(~Busy);

	// lowest slot that is not busy wins
	always_comb
	begin
		freeOneHot = '0;
		for (int i = NumUnits - 1; i >= 0; i--)
			if (!Busy[i])
				freeOneHot = NumUnits'(1) << i;
	end

	// one-cycle spawn strobe, dropped when full or game over
	always_ff @(posedge ClkPort, posedge Reset)
	begin
		if (Reset)
			Spawn <= '0;
		else if (Purchase && anyFree && !GameOver)
			Spawn <= freeOneHot;
		else
			Spawn <= '0;
	end

	// kind rides along with the strobe
	always_ff @(posedge ClkPort)
	begin
		if (Purchase)
			SpawnKind <= KindSel;
	end

endmodule

`default_nettype wire

// ==== source/Unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module Unit
(
	input wire logic ClkPort,
	input wire logic Reset,
	input wire logic Tick,
	input wire logic Spawn,
	input wire UnitPkg::unitKindT SpawnKind,
	output logic Busy,
	output GamePkg::posT Position,
	output GamePkg::damageT Attack
);

	UnitPkg::unitStateT state;
	UnitPkg::unitKindT kind;
	GamePkg::posT nextPos;

	// unit kind, taken when the slot is filled
	always_ff @(posedge ClkPort)
	begin
		if (Spawn && state == UnitPkg::Idle)
			kind <= SpawnKind;
	end

	assign nextPos = Position + UnitPkg::kindSpeed(kind);

	////////////////////////////////////////
	// march and siege
	////////////////////////////////////////

	always_ff @(posedge ClkPort, posedge Reset)
	begin
		if (Reset)
		begin
			state <= UnitPkg::Idle;
			Position <= '0;
		end
		else
		begin
			case (state)
				UnitPkg::Idle:
					if (Spawn)
					begin
						state <= UnitPkg::Marching;
						Position <= '0;
					end
				UnitPkg::Marching:
					// clamp at the tower and start the siege
					if (Tick)
					begin
						if (nextPos >= GamePkg::TowerPos)
						begin
							Position <= GamePkg::TowerPos;
							state <= UnitPkg::Sieging;
						end
						else
							Position <= nextPos;
					end
				UnitPkg::Sieging:
					state <= UnitPkg::Sieging;
				default:
					state <= UnitPkg::Idle;
			endcase
		end
	end

	assign Busy = (state != UnitPkg::Idle);
	assign Attack = (state == UnitPkg::Sieging) ? UnitPkg::kindAttack(kind) : '0;

endmodule

`default_nettype wire

// ==== source/TowerSiege.sv ====
`timescale 1ns/100ps
`default_nettype none

module TowerSiege
#(
	parameter int NumUnits = 8
)
(
	input wire logic ClkPort,
	input wire logic Reset,
	input wire logic Tick,
	input wire logic [NumUnits-1:0] Busy,
	input wire GamePkg::posT Position [NumUnits],
	input wire GamePkg::damageT Attack [NumUnits],
	output GamePkg::healthT TowerHealth,
	output GamePkg::posT FriendlyFront,
	output logic GameOver
);

	GamePkg::damageT damageSum;
	GamePkg::posT frontMax;

	////////////////////////////////////////
	// damage
	////////////////////////////////////////

	// 16 slots of at most 4 each, no overflow in 8 bits
	always_comb
	begin
		damageSum = '0;
		for (int i = 0; i < NumUnits; i++)
			damageSum = damageSum + Attack[i];
	end

	// saturate at zero, game over on the same edge
	always_ff @(posedge ClkPort, posedge Reset)
	begin
		if (Reset)
		begin
			TowerHealth <= GamePkg::TowerHealthInit;
			GameOver <= 1'b0;
		end
		else if (Tick && !GameOver)
		begin
			if (damageSum >= TowerHealth)
			begin
				TowerHealth <= '0;
				GameOver <= 1'b1;
			end
			else
				TowerHealth <= TowerHealth - damageSum;
		end
	end

	////////////////////////////////////////
	// friendly front
	////////////////////////////////////////

	// idle slots do not count
	always_comb
	begin
		frontMax = '0;
		for (int i = 0; i < NumUnits; i++)
			if (Busy[i] && Position[i] > frontMax)
				frontMax = Position[i];
	end

	always_ff @(posedge ClkPort, posedge Reset)
	begin
		if (Reset)
			FriendlyFront <= '0;
		else
			FriendlyFront <= frontMax;
	end

endmodule

`default_nettype wire

// ==== source/BattleLane.sv ====
`timescale 1ns/100ps
`default_nettype none

module BattleLane
#(
	parameter int NumUnits = 8,
	parameter int TickDiv = 1000000
)
(
	input wire logic ClkPort,
	input wire logic Reset,
	input wire logic Purchase,
	input wire UnitPkg::unitKindT KindSel,
	output GamePkg::healthT TowerHealth,
	output GamePkg::posT FriendlyFront,
	output logic GameOver
);

	logic tick;
	logic [NumUnits-1:0] spawn;
	logic [NumUnits-1:0] busy;
	UnitPkg::unitKindT spawnKind;
	GamePkg::posT unitPos [NumUnits];
	GamePkg::damageT unitAttack [NumUnits];

	GameSequencer #(.NumUnits(NumUnits), .TickDiv(TickDiv)) u_sequencer
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.Purchase(Purchase),
		.KindSel(KindSel),
		.Busy(busy),
		.GameOver(GameOver),
		.Tick(tick),
		.Spawn(spawn),
		.SpawnKind(spawnKind)
	);

	// one slot per friendly unit
	for (genvar i = 0; i < NumUnits; i++)
	begin : g_unit
		Unit u_unit
		(
			.ClkPort(ClkPort),
			.Reset(Reset),
			.Tick(tick),
			.Spawn(spawn[i]),
			.SpawnKind(spawnKind),
			.Busy(busy[i]),
			.Position(unitPos[i]),
			.Attack(unitAttack[i])
		);
	end

	TowerSiege #(.NumUnits(NumUnits)) u_siege
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.Tick(tick),
		.Busy(busy),
		.Position(unitPos),
		.Attack(unitAttack),
		.TowerHealth(TowerHealth),
		.FriendlyFront(FriendlyFront),
		.GameOver(GameOver)
	);

endmodule

`default_nettype wire

// ==== testbench/BattleModel.svh ====
`ifndef BATTLE_MODEL_SVH
`define BATTLE_MODEL_SVH

// reference lane, stepped once per rising edge
localparam int TrackEnd = 320;
localparam int FullHealth = 200;

int mCount;
logic mTick;
int mSpawnSlot;
int mSpawnKind;
// 0 free, 1 marching, 2 sieging
int mState [Slots];
int mKind [Slots];
int mPos [Slots];
int mHealth;
logic mOver;
int mFront;

// per kind, speed then attack
int speedOf [4] = '{1, 2, 1, 3};
int attackOf [4] = '{2, 1, 4, 1};

task automatic modelReset();
	mCount = 0;
	mTick = 1'b0;
	mSpawnSlot = -1;
	mSpawnKind = 0;
	mHealth = FullHealth;
	mOver = 1'b0;
	mFront = 0;
	for (int i = 0; i < Slots; i++)
	begin
		mState[i] = 0;
		mKind[i] = 0;
		mPos[i] = 0;
	end
endtask

// buy and kind are the inputs as seen at this edge
task automatic modelStep(input logic buy, input int kind);
	int freeSlot;
	int damage;
	int front;
	int newPos;
	logic oldOver;
	freeSlot = -1;
	damage = 0;
	front = 0;
	oldOver = mOver;
	for (int i = Slots - 1; i >= 0; i--)
	begin
		if (mState[i] == 0)
			freeSlot = i;
		else if (mPos[i] > front)
			front = mPos[i];
		if (mState[i] == 2)
			damage += attackOf[mKind[i]];
	end
	// units react to the tick and spawn from before this edge
	for (int i = 0; i < Slots; i++)
	begin
		newPos = mPos[i] + speedOf[mKind[i]];
		if (mState[i] == 0 && mSpawnSlot == i)
		begin
			mState[i] = 1;
			mPos[i] = 0;
			mKind[i] = mSpawnKind;
		end
		else if (mState[i] == 1 && mTick)
		begin
			mPos[i] = (newPos >= TrackEnd) ? TrackEnd : newPos;
			if (newPos >= TrackEnd)
				mState[i] = 2;
		end
	end
	mFront = front;
	if (mTick && !oldOver)
	begin
		mHealth = (damage >= mHealth) ? 0 : mHealth - damage;
		mOver = (mHealth == 0);
	end
	mSpawnSlot = (buy && freeSlot >= 0 && !oldOver) ? freeSlot : -1;
	if (buy)
		mSpawnKind = kind;
	// divider holds once the tower is down
	if (oldOver)
		mTick = 1'b0;
	else
	begin
		mTick = (mCount == Div - 1);
		mCount = (mCount == Div - 1) ? 0 : mCount + 1;
	end
endtask

`endif

// ==== testbench/BattleLaneTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module BattleLaneTb;

	localparam int Slots = 8;
	localparam int Div = 4;

	logic ClkPort;
	logic Reset;
	logic Purchase;
	UnitPkg::unitKindT KindSel;
	GamePkg::healthT TowerHealth;
	GamePkg::posT FriendlyFront;
	logic GameOver;

	logic [31:0] lfsr;
	int errCount;
	int testCount;
	int errBefore;
	int waited;
	GamePkg::posT frozenFront;

	`include "BattleModel.svh"

	BattleLane #(.NumUnits(Slots), .TickDiv(Div)) u_dut
	(
		.ClkPort(ClkPort),
		.Reset(Reset),
		.Purchase(Purchase),
		.KindSel(KindSel),
		.TowerHealth(TowerHealth),
		.FriendlyFront(FriendlyFront),
		.GameOver(GameOver)
	);

	initial
	begin
		ClkPort = 1'b0;
		forever
			#10 ClkPort = ~ClkPort;
	end

	////////////////////////////////////////
	// random bits
	////////////////////////////////////////

	// galois form shifting right
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsrStep(lfsr);
		end
		return v;
	endfunction

	////////////////////////////////////////
	// compares
	////////////////////////////////////////

	task automatic checkHealth(input GamePkg::healthT got, input GamePkg::healthT want);
		if (got !== want)
		begin
			errCount++;
			$display("ERR %0t TowerHealth got %0d expected %0d", $time, got, want);
		end
	endtask

	task automatic checkFront(input GamePkg::posT got, input GamePkg::posT want);
		if (got !== want)
		begin
			errCount++;
			$display("ERR %0t FriendlyFront got %0d expected %0d", $time, got, want);
		end
	endtask

	task automatic checkFlag(input logic got, input logic want);
		if (got !== want)
		begin
			errCount++;
			$display("ERR %0t GameOver got %b expected %b", $time, got, want);
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic applyReset();
		Reset = 1'b1;
		Purchase = 1'b0;
		KindSel = '0;
		repeat (8) @(posedge ClkPort);
		#2;
		Reset = 1'b0;
		modelReset();
	endtask

	// model step and compares on each edge before the next inputs
	task automatic clockCycle(input logic buy, input int kind);
		@(posedge ClkPort);
		#1;
		modelStep(Purchase, KindSel);
		checkHealth(TowerHealth, GamePkg::healthT'(mHealth));
		checkFront(FriendlyFront, GamePkg::posT'(mFront));
		checkFlag(GameOver, mOver);
		#1;
		Purchase = buy;
		KindSel = UnitPkg::unitKindT'(kind);
	endtask

	task automatic buyAndWait(input int gap);
		clockCycle(1'b1, randBits(2));
		for (int i = 0; i < gap; i++)
			clockCycle(1'b0, 0);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("test %0d %s: %s", testCount, name, (errCount == errBefore) ? "ok" : "errors");
		errBefore = errCount;
	endtask

	initial
	begin
		lfsr = 32'h0522_7577;
		errCount = 0;
		testCount = 0;
		errBefore = 0;
		applyReset();
		checkHealth(TowerHealth, GamePkg::healthT'(FullHealth));
		checkFront(FriendlyFront, '0);
		checkFlag(GameOver, 1'b0);
		finishTest("reset values");

		for (int n = 0; n < 12; n++)
		begin
			if (randBits(1))
				buyAndWait(3 + randBits(3));
			else
				clockCycle(1'b0, 0);
		end
		for (int n = 0; n < 100; n++)
			clockCycle(1'b0, 0);
		finishTest("marching");

		// nine buys into eight empty slots
		applyReset();
		for (int n = 0; n < 9; n++)
			buyAndWait(3);
		finishTest("full slots");

		waited = 0;
		while (TowerHealth == GamePkg::healthT'(FullHealth) && waited < 3000)
		begin
			clockCycle(1'b0, 0);
			waited++;
		end
		if (TowerHealth == GamePkg::healthT'(FullHealth))
		begin
			errCount++;
			$display("tower health never dropped within 3000 cycles");
		end
		for (int n = 0; n < 40; n++)
			clockCycle(1'b0, 0);
		finishTest("siege damage");

		waited = 0;
		while (GameOver !== 1'b1 && waited < 3000)
		begin
			clockCycle(1'b0, 0);
			waited++;
		end
		if (GameOver === 1'b1)
		begin
			frozenFront = GamePkg::posT'(mFront);
			checkHealth(TowerHealth, '0);
			// purchases after the end must change nothing
			for (int n = 0; n < 10; n++)
			begin
				buyAndWait(3);
				checkHealth(TowerHealth, '0);
				checkFront(FriendlyFront, frozenFront);
				checkFlag(GameOver, 1'b1);
			end
		end
		else
		begin
			errCount++;
			$display("timed out waiting for GameOver after 3000 cycles");
		end
		finishTest("game over");

		$display("%0d tests run, %0d errors", testCount, errCount);
		if (errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== BattleLane.f ====
+incdir+testbench
source/GamePkg.sv
source/UnitPkg.sv
source/GameSequencer.sv
source/Unit.sv
source/TowerSiege.sv
source/BattleLane.sv
testbench/BattleLaneTb.sv
